// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_n64_ppu
FILELIST  ?= n64_ppu_top.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== gamma_stage.sv ====
// Second pipeline stage: maps 7-bit colours to 8 bits through the selected gamma curve
`timescale 1ns/1ps

module gamma_stage
  import vid_types_pkg::*;
  import ppu_cfg_pkg::*;
(
  input  logic     N64_CLK_i,
  input  logic     rst_n_i,
  input  gamma_e   gamma_i,
  input  pix_in_t  pix_i,
  input  logic     pix_valid_i,
  output pix_out_t pix_o,
  output logic     pix_valid_o
);

  // One colour through the curve
  function automatic logic [COLOR_W_OUT-1:0] gamma_map(
    input logic [COLOR_W_IN-1:0] c,
    input gamma_e                g
  );
    logic [2*COLOR_W_IN-1:0] sq;
    logic [2*COLOR_W_IN-1:0] sh;
    sq = c * c;
    sh = sq >> 6;
    if (g == GAMMA_LINEAR) begin
      // Replicate the MSB so full scale stays full scale
      gamma_map = {c, c[COLOR_W_IN-1]};
    end else if (sh > (2**COLOR_W_OUT - 1)) begin
      gamma_map = '1;
    end else begin
      gamma_map = sh[COLOR_W_OUT-1:0];
    end
  endfunction

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= pix_valid_i;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      pix_o.r    <= gamma_map(pix_i.r, gamma_i);
      pix_o.g    <= gamma_map(pix_i.g, gamma_i);
      pix_o.b    <= gamma_map(pix_i.b, gamma_i);
      pix_o.sync <= pix_i.sync;
    end
  end

endmodule

// ==== n64_ppu_top.f ====
vid_types_pkg.sv
ppu_cfg_pkg.sv
n64_vdemux.sv
n64_vinfo.sv
gamma_stage.sv
scanline_stage.sv
n64_ppu_top.sv
tb_clkgen.sv
tb_n64_ppu.sv

// ==== n64_ppu_top.sv ====
// Top level of the N64 video input pipeline: demux, gamma, scanlines and mode detection
`timescale 1ns/1ps

module n64_ppu_top
  import vid_types_pkg::*;
  import ppu_cfg_pkg::*;
#(
  parameter int LINES_PAL_MIN = 300
) (
  input  logic                     N64_CLK_i,
  input  logic                     rst_n_i,
  input  logic                     nVDSYNC_i,
  input  logic [COLOR_W_IN-1:0]    VD_i,
  input  ppu_cfg_t                 cfg_i,
  output ppu_state_t               ppu_state_o,
  output logic [3*COLOR_W_OUT-1:0] VD_o,
  output logic                     HSYNC_o,
  output logic                     VSYNC_o,
  output logic                     DE_o,
  output logic                     pix_valid_o
);

  pix_in_t   demux_pix;
  logic      demux_pix_valid;
  n64_sync_t demux_sync;
  logic      demux_sync_valid;
  pix_out_t  gamma_pix;
  logic      gamma_pix_valid;

  // ==================================================
  // Input side
  // ==================================================

  n64_vdemux i_vdemux (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .nVDSYNC_i    (nVDSYNC_i),
    .VD_i         (VD_i),
    .color16_en_i (cfg_i.color16_en),
    .pix_o        (demux_pix),
    .pix_valid_o  (demux_pix_valid),
    .sync_o       (demux_sync),
    .sync_valid_o (demux_sync_valid)
  );

  n64_vinfo #(
    .LINES_PAL_MIN (LINES_PAL_MIN)
  ) i_vinfo (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .sync_i       (demux_sync),
    .sync_valid_i (demux_sync_valid),
    .state_o      (ppu_state_o)
  );

  // ==================================================
  // Post-processing
  // ==================================================

  gamma_stage i_gamma (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .gamma_i     (cfg_i.gamma),
    .pix_i       (demux_pix),
    .pix_valid_i (demux_pix_valid),
    .pix_o       (gamma_pix),
    .pix_valid_o (gamma_pix_valid)
  );

  scanline_stage i_scanline (
    .N64_CLK_i     (N64_CLK_i),
    .rst_n_i       (rst_n_i),
    .sl_en_i       (cfg_i.sl_en),
    .sl_strength_i (cfg_i.sl_strength),
    .pix_i         (gamma_pix),
    .pix_valid_i   (gamma_pix_valid),
    .VD_o          (VD_o),
    .HSYNC_o       (HSYNC_o),
    .VSYNC_o       (VSYNC_o),
    .DE_o          (DE_o),
    .pix_valid_o   (pix_valid_o)
  );

endmodule

// ==== n64_vdemux.sv ====
// First pipeline stage: splits the multiplexed N64 video bus into pixels with optional 16-bit colour
`timescale 1ns/1ps

module n64_vdemux
  import vid_types_pkg::*;
(
  input  logic                  N64_CLK_i,
  input  logic                  rst_n_i,
  input  logic                  nVDSYNC_i,
  input  logic [COLOR_W_IN-1:0] VD_i,
  input  logic                  color16_en_i,
  output pix_in_t               pix_o,
  output logic                  pix_valid_o,
  output n64_sync_t             sync_o,
  output logic                  sync_valid_o
);

  demux_phase_e          phase_q;
  n64_sync_t             sync_q;
  logic [COLOR_W_IN-1:0] r_q;
  logic [COLOR_W_IN-1:0] g_q;
  logic [COLOR_W_IN-1:0] col_mask;

  // 16-bit mode drops the two LSBs of each colour
  assign col_mask = color16_en_i ? {{(COLOR_W_IN-2){1'b1}}, 2'b00} : '1;

  // ==================================================
  // Phase tracking
  // ==================================================

  // nVDSYNC low always restarts the sequence; after reset we sit in
  // PH_SYNC until the first sync word shows up
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q      <= PH_SYNC;
      pix_valid_o  <= 1'b0;
      sync_valid_o <= 1'b0;
    end else begin
      sync_valid_o <= ~nVDSYNC_i;
      pix_valid_o  <= nVDSYNC_i && (phase_q == PH_B);
      if (!nVDSYNC_i) begin
        phase_q <= PH_R;
      end else begin
        case (phase_q)
          PH_R:    phase_q <= PH_G;
          PH_G:    phase_q <= PH_B;
          default: phase_q <= PH_SYNC;
        endcase
      end
    end
  end

  // ==================================================
  // Word capture
  // ==================================================

  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_q <= VD_i[3:0];
    end else begin
      case (phase_q)
        PH_R: r_q <= VD_i;
        PH_G: g_q <= VD_i;
        PH_B: begin
          // B comes straight from the bus, pixel is complete
          pix_o.r    <= r_q & col_mask;
          pix_o.g    <= g_q & col_mask;
          pix_o.b    <= VD_i & col_mask;
          pix_o.sync <= sync_q;
        end
        default: ;
      endcase
    end
  end

  // Sync word is visible together with its strobe one cycle later
  assign sync_o = sync_q;

endmodule

// ==== n64_vinfo.sv ====
// Video mode detector: counts lines per field from the sync stream and flags presence, PAL and 480i
`timescale 1ns/1ps

module n64_vinfo
  import vid_types_pkg::*;
  import ppu_cfg_pkg::*;
#(
  parameter int LINES_PAL_MIN = 300
) (
  input  logic       N64_CLK_i,
  input  logic       rst_n_i,
  input  n64_sync_t  sync_i,
  input  logic       sync_valid_i,
  output ppu_state_t state_o
);

  localparam int LINE_CNT_W = 10;
  localparam logic [LINE_CNT_W-1:0] PAL_MIN = LINE_CNT_W'(LINES_PAL_MIN);

  logic                  hs_prev_q;
  logic                  vs_prev_q;
  logic                  hs_fall;
  logic                  vs_fall;
  logic [LINE_CNT_W-1:0] line_cnt_q;
  logic [LINE_CNT_W-1:0] lines_prev_q;
  // Saturating count of vsync falling edges seen so far
  logic [1:0]            vs_cnt_q;
  ppu_state_t            state_q;

  assign hs_fall = hs_prev_q & ~sync_i.hsync_n;
  assign vs_fall = vs_prev_q & ~sync_i.vsync_n;

  // ==================================================
  // Line counting and mode flags
  // ==================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_prev_q    <= 1'b1;
      vs_prev_q    <= 1'b1;
      line_cnt_q   <= '0;
      lines_prev_q <= '0;
      vs_cnt_q     <= '0;
      state_q      <= '0;
    end else if (sync_valid_i) begin
      hs_prev_q <= sync_i.hsync_n;
      vs_prev_q <= sync_i.vsync_n;
      if (vs_fall) begin
        // line_cnt_q now holds the length of the field that just ended
        lines_prev_q           <= line_cnt_q;
        state_q.pal            <= (line_cnt_q >= PAL_MIN);
        // Only compare once two complete fields have been counted
        state_q.interlaced     <= (vs_cnt_q == 2'd2) && (line_cnt_q != lines_prev_q);
        state_q.vdata_detected <= (vs_cnt_q != 2'd0);
        if (vs_cnt_q != 2'd2) begin
          vs_cnt_q <= vs_cnt_q + 2'd1;
        end
        // First line of the new field usually starts on this very word
        line_cnt_q <= hs_fall ? LINE_CNT_W'(1) : '0;
      end else if (hs_fall) begin
        line_cnt_q <= line_cnt_q + LINE_CNT_W'(1);
      end
    end
  end

  assign state_o = state_q;

endmodule

// ==== ppu_cases.txt ====
// color16_en gamma sl_en sl_strength pixels_per_line lines_a lines_b pal interlaced
// All values hex, gamma 0 is linear and 1 is square
0 0 0 00 4 106 106 0 0
1 1 0 00 3 106 107 0 1
0 0 1 80 3 138 139 1 1
1 1 1 c0 2 106 107 0 1
0 1 1 ff 2 138 138 1 0

// ==== ppu_cfg_pkg.sv ====
// Configuration and status types of the post-processor; imported where cfg or state is used
package ppu_cfg_pkg;

  // ==================================================
  // Configuration
  // ==================================================

  // Selectable transfer curve of the gamma stage
  typedef enum logic {
    GAMMA_LINEAR,
    GAMMA_SQUARE
  } gamma_e;

  // Static settings, held constant while video runs
  typedef struct packed {
    logic       color16_en;
    gamma_e     gamma;
    logic       sl_en;
    // Scanline dimming, 0 is none and 255 is nearly black
    logic [7:0] sl_strength;
  } ppu_cfg_t;

  // ==================================================
  // Status
  // ==================================================

  // Detected input video mode
  typedef struct packed {
    logic vdata_detected;
    logic pal;
    logic interlaced;
  } ppu_state_t;

endpackage

// ==== scanline_stage.sv ====
// Final pipeline stage: dims odd lines when scanlines are on and drives the video outputs
`timescale 1ns/1ps

module scanline_stage
  import vid_types_pkg::*;
(
  input  logic                     N64_CLK_i,
  input  logic                     rst_n_i,
  input  logic                     sl_en_i,
  input  logic [7:0]               sl_strength_i,
  input  pix_out_t                 pix_i,
  input  logic                     pix_valid_i,
  output logic [3*COLOR_W_OUT-1:0] VD_o,
  output logic                     HSYNC_o,
  output logic                     VSYNC_o,
  output logic                     DE_o,
  output logic                     pix_valid_o
);

  logic hs_prev_q;
  logic vs_prev_q;
  logic line_odd_q;
  logic line_odd;
  logic dim_en;

  // c - c*s/256, never below zero
  function automatic logic [COLOR_W_OUT-1:0] dim(
    input logic [COLOR_W_OUT-1:0] c,
    input logic [7:0]             s
  );
    logic [COLOR_W_OUT+7:0] prod;
    prod = c * s;
    dim  = c - prod[COLOR_W_OUT+7:8];
  endfunction

  // ==================================================
  // Line parity
  // ==================================================

  // Parity of the line the current pixel belongs to; the edge pixel
  // already counts as part of the new line
  always_comb begin
    line_odd = line_odd_q;
    if (vs_prev_q && !pix_i.sync.vsync_n) begin
      line_odd = 1'b0;
    end else if (hs_prev_q && !pix_i.sync.hsync_n) begin
      line_odd = ~line_odd_q;
    end
  end

  assign dim_en = sl_en_i & line_odd;

  // ==================================================
  // Output registers
  // ==================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_prev_q   <= 1'b1;
      vs_prev_q   <= 1'b1;
      line_odd_q  <= 1'b0;
      VD_o        <= '0;
      HSYNC_o     <= 1'b1;
      VSYNC_o     <= 1'b1;
      DE_o        <= 1'b0;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        hs_prev_q  <= pix_i.sync.hsync_n;
        vs_prev_q  <= pix_i.sync.vsync_n;
        line_odd_q <= line_odd;
        HSYNC_o    <= pix_i.sync.hsync_n;
        VSYNC_o    <= pix_i.sync.vsync_n;
        DE_o       <= pix_i.sync.hsync_n & pix_i.sync.vsync_n;
        if (dim_en) begin
          VD_o <= {dim(pix_i.r, sl_strength_i), dim(pix_i.g, sl_strength_i),
                   dim(pix_i.b, sl_strength_i)};
        end else begin
          VD_o <= {pix_i.r, pix_i.g, pix_i.b};
        end
      end
    end
  end

endmodule

// ==== tb_clkgen.sv ====
// Testbench clock and reset source; reset is held for a few cycles at start and on each request
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2,
  parameter int DRIVE_NS   = 2
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_n_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  // Release lands just after a rising edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    forever begin
      repeat (RST_CYCLES) @(posedge clk_o);
      #(DRIVE_NS) rst_n_o = 1'b1;
      @(posedge rst_req_i);
      rst_n_o = 1'b0;
    end
  end

endmodule

// ==== tb_n64_ppu.sv ====
// Testbench top: runs the cases of ppu_cases.txt through the N64 video pipeline and checks each pixel
`timescale 1ns/1ps

module tb_n64_ppu
  import vid_types_pkg::*;
  import ppu_cfg_pkg::*;
();

  localparam int          CLK_NS     = 40;
  localparam int          DRIVE_NS   = 2;
  localparam int          CASE_WORDS = 9;
  localparam int          MAX_CASES  = 16;
  localparam int          LATENCY    = 3;
  localparam logic [31:0] SEED       = 32'h326a04e3;

  // One pixel as it should leave the DUT
  typedef struct packed {
    logic [31:0] b_cyc;
    logic [23:0] vd;
    logic        hs;
    logic        vs;
    logic        de;
  } exp_pix_t;

  logic        clk;
  logic        rst_n;
  logic        rst_req = 1'b0;
  logic        nvdsync = 1'b1;
  logic [6:0]  vd_in = '0;
  ppu_cfg_t    cfg = '0;
  ppu_state_t  state;
  logic [23:0] vd_out;
  logic        hsync;
  logic        vsync;
  logic        de;
  logic        pix_valid;

  logic [31:0] case_mem [MAX_CASES*CASE_WORDS];
  exp_pix_t    exp_q[$];
  logic [31:0] rnd_state = SEED;
  int          cyc = 0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          wd_cycles = 0;

  tb_clkgen #(
    .PERIOD_NS  (CLK_NS),
    .RST_CYCLES (2),
    .DRIVE_NS   (DRIVE_NS)
  ) i_clkgen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_n_o   (rst_n)
  );

  n64_ppu_top #(
    .LINES_PAL_MIN (300)
  ) i_dut (
    .N64_CLK_i   (clk),
    .rst_n_i     (rst_n),
    .nVDSYNC_i   (nvdsync),
    .VD_i        (vd_in),
    .cfg_i       (cfg),
    .ppu_state_o (state),
    .VD_o        (vd_out),
    .HSYNC_o     (hsync),
    .VSYNC_o     (vsync),
    .DE_o        (de),
    .pix_valid_o (pix_valid)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // ==================================================
  // Helpers and reference model
  // ==================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 7-bit bus colour to the 8-bit value expected on VD_o
  function automatic logic [7:0] expect_color(input ppu_cfg_t c, input logic [6:0] raw,
                                              input logic odd_line);
    int v;
    v = int'(raw);
    if (c.color16_en) v = v & 'h7c;
    if (c.gamma == GAMMA_LINEAR) begin
      v = v * 2 + (v >> 6);
    end else begin
      v = (v * v) >> 6;
      if (v > 255) v = 255;
    end
    if (c.sl_en && odd_line) v = v - ((v * int'(c.sl_strength)) >> 8);
    return 8'(v);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, want, got);
      errors++;
    end
  endtask

  task automatic drive_word(input logic nvd, input logic [6:0] data);
    @(posedge clk);
    #(DRIVE_NS);
    nvdsync = nvd;
    vd_in   = data;
  endtask

  // Sync word then R, G and B, and the matching expected output
  task automatic send_pixel(input logic hs_n, input logic vs_n, input logic odd_line);
    logic [6:0] r;
    logic [6:0] g;
    logic [6:0] b;
    exp_pix_t   e;
    rnd_state = xorshift32(rnd_state);
    r = rnd_state[6:0];
    g = rnd_state[14:8];
    b = rnd_state[22:16];
    drive_word(1'b0, {3'b000, vs_n, 1'b1, hs_n, hs_n & vs_n});
    drive_word(1'b1, r);
    drive_word(1'b1, g);
    drive_word(1'b1, b);
    e.b_cyc = cyc;
    e.vd    = {expect_color(cfg, r, odd_line), expect_color(cfg, g, odd_line),
               expect_color(cfg, b, odd_line)};
    e.hs    = hs_n;
    e.vs    = vs_n;
    e.de    = hs_n & vs_n;
    exp_q.push_back(e);
  endtask

  // Wait for the pipeline to empty, giving up after a few pixel times
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 16) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Error at %0d ns: %0d pixels never came out of the DUT", $time, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic run_case(input int idx);
    int base;
    int ppl;
    int lines_a;
    int lines_b;
    int lines;
    int errs_at_start;
    base          = idx * CASE_WORDS;
    ppl           = int'(case_mem[base+4]);
    lines_a       = int'(case_mem[base+5]);
    lines_b       = int'(case_mem[base+6]);
    errs_at_start = errors;
    exp_q.delete();
    @(posedge clk);
    #(DRIVE_NS);
    rst_req         = 1'b1;
    nvdsync         = 1'b1;
    vd_in           = '0;
    cfg.color16_en  = case_mem[base][0];
    cfg.gamma       = case_mem[base+1][0] ? GAMMA_SQUARE : GAMMA_LINEAR;
    cfg.sl_en       = case_mem[base+2][0];
    cfg.sl_strength = case_mem[base+3][7:0];
    wait (!rst_n);
    wait (rst_n);
    rst_req = 1'b0;
    check_value("pix_valid_o", 32'(pix_valid), 0);
    check_value("DE_o", 32'(de), 0);
    check_value("VD_o", 32'(vd_out), 0);
    check_value("HSYNC_o", 32'(hsync), 1);
    check_value("VSYNC_o", 32'(vsync), 1);
    check_value("ppu_state_o", 32'(state), 0);
    // Fields A, B, A; hsync low on the first pixel, vsync low on the first line
    for (int f = 0; f < 3; f++) begin
      lines = (f == 1) ? lines_b : lines_a;
      for (int l = 0; l < lines; l++) begin
        for (int p = 0; p < ppl; p++) begin
          send_pixel(p != 0, l != 0, (l % 2) == 1);
        end
      end
    end
    drain_pipeline();
    @(posedge clk);
    #(DRIVE_NS);
    check_value("ppu_state_o.vdata_detected", 32'(state.vdata_detected), 1);
    check_value("ppu_state_o.pal", 32'(state.pal), case_mem[base+7]);
    check_value("ppu_state_o.interlaced", 32'(state.interlaced), case_mem[base+8]);
    if (errors == errs_at_start) tests_passed++;
    else tests_failed++;
    $display("Test %0d done: %0d pixels per line, fields of %0d and %0d lines, %0d errors",
             idx, ppl, lines_a, lines_b, errors - errs_at_start);
  endtask

  // ==================================================
  // Output monitor and watchdog
  // ==================================================

  // Outputs settle well before the falling edge
  always @(negedge clk) begin : monitor
    exp_pix_t e;
    if (rst_n && pix_valid) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0d ns: DUT sent a pixel that was never driven", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_value("pix_valid_o latency", cyc - e.b_cyc, LATENCY);
        check_value("VD_o", 32'(vd_out), 32'(e.vd));
        check_value("HSYNC_o", 32'(hsync), 32'(e.hs));
        check_value("VSYNC_o", 32'(vsync), 32'(e.vs));
        check_value("DE_o", 32'(de), 32'(e.de));
      end
    end
  end

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the cases did not finish within %0d cycles", wd_cycles);
    $display("Simulation failed");
    $finish;
  end

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin : main
    int n_cases;
    int total;
    $readmemh("ppu_cases.txt", case_mem);
    n_cases = 0;
    total   = 0;
    // A pixel count of zero marks the end of the list
    while (n_cases < MAX_CASES && case_mem[n_cases*CASE_WORDS+4] != 0) begin
      total += 40 + 4 * int'(case_mem[n_cases*CASE_WORDS+4]) *
               (2 * int'(case_mem[n_cases*CASE_WORDS+5]) + int'(case_mem[n_cases*CASE_WORDS+6]));
      n_cases++;
    end
    wd_cycles = 2 * total + 100;
    if (n_cases == 0) begin
      $display("Error: no test cases were read from ppu_cases.txt");
      errors++;
    end
    wait (rst_n);
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             n_cases, tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vid_types_pkg.sv ====
// Shared video bus widths, pixel and sync structs and demux phases; imported by every RTL stage
package vid_types_pkg;

  // ==================================================
  // Bus widths
  // ==================================================

  // One colour as it arrives on the N64 bus
  localparam int COLOR_W_IN = 7;

  // One colour after expansion in the gamma stage
  localparam int COLOR_W_OUT = 8;

  // ==================================================
  // Sync and pixel types
  // ==================================================

  // Order matches VD_i[3:0] of the sync word
  typedef struct packed {
    logic vsync_n;
    logic clamp_n;
    logic hsync_n;
    logic csync_n;
  } n64_sync_t;

  typedef struct packed {
    logic [COLOR_W_IN-1:0] r;
    logic [COLOR_W_IN-1:0] g;
    logic [COLOR_W_IN-1:0] b;
    n64_sync_t             sync;
  } pix_in_t;

  typedef struct packed {
    logic [COLOR_W_OUT-1:0] r;
    logic [COLOR_W_OUT-1:0] g;
    logic [COLOR_W_OUT-1:0] b;
    n64_sync_t              sync;
  } pix_out_t;

  // Which word of the four-word sequence is on the bus
  typedef enum logic [1:0] {
    PH_SYNC,
    PH_R,
    PH_G,
    PH_B
  } demux_phase_e;

endpackage
